//--- logic/cpu_macros.svh
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

`define WORD_SIZE 16
`define REG_COUNT 4

// Opcodes
`define OPC_BNE   4'd0
`define OPC_BEQ   4'd1
`define OPC_BGZ   4'd2
`define OPC_BLZ   4'd3
`define OPC_ADI   4'd4
`define OPC_ORI   4'd5
`define OPC_LHI   4'd6
`define OPC_LWD   4'd7
`define OPC_SWD   4'd8
`define OPC_JMP   4'd9
`define OPC_JAL   4'd10
`define OPC_RTYPE 4'd15

// Function codes of the R-type group
`define FN_ADD 6'd0
`define FN_SUB 6'd1
`define FN_AND 6'd2
`define FN_ORR 6'd3
`define FN_NOT 6'd4
`define FN_TCP 6'd5
`define FN_SHL 6'd6
`define FN_SHR 6'd7
`define FN_JPR 6'd25
`define FN_JRL 6'd26
`define FN_WWD 6'd28
`define FN_HLT 6'd29

// ALU operations
`define ALU_ADD    4'd0
`define ALU_SUB    4'd1
`define ALU_AND    4'd2
`define ALU_OR     4'd3
`define ALU_NOT    4'd4
`define ALU_TCP    4'd5
`define ALU_SHL    4'd6
`define ALU_SHR    4'd7
`define ALU_LHI    4'd8
`define ALU_PASS_B 4'd9
`define ALU_BNE    4'd10
`define ALU_BEQ    4'd11
`define ALU_BGZ    4'd12
`define ALU_BLZ    4'd13

// Datapath select codes
`define OPA_PC   1'b0
`define OPA_REG  1'b1
`define OPB_REG  2'd0
`define OPB_ONE  2'd1
`define OPB_SEXT 2'd2
`define OPB_ZEXT 2'd3
`define DEST_RD  2'd0
`define DEST_RT  2'd1
`define DEST_R2  2'd2
`define WB_ALU   2'd0
`define WB_MDR   2'd1
`define WB_PC    2'd2

`endif

//--- logic/cpu_pkg.sv
`default_nettype none

`include "cpu_macros.svh"

package cpu_pkg;

	// Data, address and instruction word
	typedef logic [`WORD_SIZE-1:0] word_t;

	typedef logic [$clog2(`REG_COUNT)-1:0] reg_addr_t;

	// Holds one of the ALU_ codes
	typedef logic [3:0] alu_sel_t;

	typedef enum logic [2:0] {
		FETCH,
		DECODE,
		EXECUTE,
		MEMORY,
		WRITEBACK,
		HALTED
	} ctrl_state_t;

endpackage

`default_nettype wire

//--- logic/register_file.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module register_file (
	input  wire                 clk,
	input  wire                 reset_n,
	input  cpu_pkg::reg_addr_t  read_addr1,
	input  cpu_pkg::reg_addr_t  read_addr2,
	input  cpu_pkg::reg_addr_t  write_addr,
	input  cpu_pkg::word_t      write_data,
	input  wire                 write_en,
	output cpu_pkg::word_t      read_data1,
	output cpu_pkg::word_t      read_data2
);
	import cpu_pkg::*;

	word_t regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (write_en) begin
			regs[write_addr] <= write_data;
		end
	end

	// Reads see the old value during a write cycle
	assign read_data1 = regs[read_addr1];
	assign read_data2 = regs[read_addr2];

endmodule

`default_nettype wire

//--- logic/alu.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module alu (
	input  cpu_pkg::word_t    a,
	input  cpu_pkg::word_t    b,
	input  cpu_pkg::alu_sel_t sel,
	output cpu_pkg::word_t    result,
	output logic              bcond
);

	always_comb begin
		result = '0;
		bcond  = 1'b0;
		case (sel)
			`ALU_ADD: result = a + b;
			`ALU_SUB: result = a - b;
			`ALU_AND: result = a & b;
			`ALU_OR: result = a | b;
			`ALU_NOT: result = ~a;
			`ALU_TCP: result = ~a + 1'b1;
			`ALU_SHL: result = a << 1;
			// Arithmetic shift keeps the sign bit
			`ALU_SHR: result = {a[`WORD_SIZE-1], a[`WORD_SIZE-1:1]};
			`ALU_LHI: result = {b[7:0], 8'h00};
			`ALU_PASS_B: result = b;
			`ALU_BNE: begin
				result = a + b;
				bcond  = (a != b);
			end
			`ALU_BEQ: begin
				result = a + b;
				bcond  = (a == b);
			end
			// Signed compare of a against zero with b unused
			`ALU_BGZ: begin
				result = a + b;
				bcond  = ($signed(a) > 0);
			end
			`ALU_BLZ: begin
				result = a + b;
				bcond  = a[`WORD_SIZE-1];
			end
			default: begin
				result = '0;
				bcond  = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- logic/control_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module control_unit (
	input  wire               clk,
	input  wire               reset_n,
	input  wire  [3:0]        opcode,
	input  wire  [5:0]        func,
	input  wire               bcond,
	output logic              pc_write,
	output logic              branch_write,
	output logic              ir_write,
	output logic              mdr_write,
	output logic              i_or_d,
	output logic              read_m,
	output logic              write_m,
	output logic              reg_write,
	output logic [1:0]        reg_dest,
	output logic [1:0]        reg_src,
	output logic              alu_a_sel,
	output logic [1:0]        alu_b_sel,
	output cpu_pkg::alu_sel_t alu_sel,
	output logic              wwd,
	output logic              done,
	output logic              halt
);
	import cpu_pkg::*;

	ctrl_state_t state;
	ctrl_state_t next_state;

	// R-type func to ALU operation
	function automatic alu_sel_t func_to_alu(input logic [5:0] fn);
		alu_sel_t op;
		case (fn)
			`FN_SUB: op = `ALU_SUB;
			`FN_AND: op = `ALU_AND;
			`FN_ORR: op = `ALU_OR;
			`FN_NOT: op = `ALU_NOT;
			`FN_TCP: op = `ALU_TCP;
			`FN_SHL: op = `ALU_SHL;
			`FN_SHR: op = `ALU_SHR;
			default: op = `ALU_ADD;
		endcase
		return op;
	endfunction

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= FETCH;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		pc_write     = 1'b0;
		branch_write = 1'b0;
		ir_write     = 1'b0;
		mdr_write    = 1'b0;
		i_or_d       = 1'b0;
		read_m       = 1'b0;
		write_m      = 1'b0;
		reg_write    = 1'b0;
		reg_dest     = `DEST_RT;
		reg_src      = `WB_ALU;
		alu_a_sel    = `OPA_PC;
		alu_b_sel    = `OPB_REG;
		alu_sel      = `ALU_ADD;
		wwd          = 1'b0;
		done         = 1'b0;
		halt         = 1'b0;
		next_state   = state;

		case (state)
			FETCH: begin
				read_m     = 1'b1;
				ir_write   = 1'b1;
				// PC+1 through the ALU
				pc_write   = 1'b1;
				alu_b_sel  = `OPB_ONE;
				next_state = DECODE;
			end
			DECODE: begin
				// Branch target PC+1+imm goes to the ALU output register
				alu_b_sel = `OPB_SEXT;
				if (opcode == `OPC_RTYPE && func == `FN_HLT) begin
					done       = 1'b1;
					next_state = HALTED;
				end else begin
					next_state = EXECUTE;
				end
			end
			EXECUTE: begin
				alu_a_sel  = `OPA_REG;
				next_state = FETCH;
				case (opcode)
					`OPC_RTYPE: begin
						case (func)
							`FN_WWD: begin
								wwd  = 1'b1;
								done = 1'b1;
							end
							`FN_JPR: begin
								pc_write = 1'b1;
								done     = 1'b1;
							end
							// Link first, jump in writeback
							`FN_JRL: begin
								reg_write  = 1'b1;
								reg_dest   = `DEST_R2;
								reg_src    = `WB_PC;
								next_state = WRITEBACK;
							end
							`FN_ADD, `FN_SUB, `FN_AND, `FN_ORR,
							`FN_NOT, `FN_TCP, `FN_SHL, `FN_SHR: begin
								alu_sel    = func_to_alu(func);
								next_state = WRITEBACK;
							end
							default: done = 1'b1;
						endcase
					end
					`OPC_ADI: begin
						alu_b_sel  = `OPB_SEXT;
						next_state = WRITEBACK;
					end
					`OPC_ORI: begin
						alu_b_sel  = `OPB_ZEXT;
						alu_sel    = `ALU_OR;
						next_state = WRITEBACK;
					end
					`OPC_LHI: begin
						alu_b_sel  = `OPB_ZEXT;
						alu_sel    = `ALU_LHI;
						next_state = WRITEBACK;
					end
					`OPC_LWD, `OPC_SWD: begin
						alu_b_sel  = `OPB_SEXT;
						next_state = MEMORY;
					end
					`OPC_BNE, `OPC_BEQ, `OPC_BGZ, `OPC_BLZ: begin
						alu_sel      = `ALU_BNE + alu_sel_t'(opcode);
						// Taken only when the compare holds
						branch_write = bcond;
						done         = 1'b1;
					end
					`OPC_JMP: begin
						pc_write = 1'b1;
						done     = 1'b1;
					end
					`OPC_JAL: begin
						reg_write  = 1'b1;
						reg_dest   = `DEST_R2;
						reg_src    = `WB_PC;
						next_state = WRITEBACK;
					end
					default: done = 1'b1;
				endcase
			end
			MEMORY: begin
				i_or_d = 1'b1;
				if (opcode == `OPC_LWD) begin
					read_m     = 1'b1;
					mdr_write  = 1'b1;
					next_state = WRITEBACK;
				end else begin
					write_m    = 1'b1;
					done       = 1'b1;
					next_state = FETCH;
				end
			end
			WRITEBACK: begin
				done       = 1'b1;
				next_state = FETCH;
				if (opcode == `OPC_JAL || (opcode == `OPC_RTYPE && func == `FN_JRL)) begin
					pc_write = 1'b1;
				end else begin
					reg_write = 1'b1;
					reg_dest  = (opcode == `OPC_RTYPE) ? `DEST_RD : `DEST_RT;
					reg_src   = (opcode == `OPC_LWD) ? `WB_MDR : `WB_ALU;
				end
			end
			HALTED: halt = 1'b1;
			default: next_state = FETCH;
		endcase
	end

endmodule

`default_nettype wire

//--- logic/cpu.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module cpu (
	input  wire            clk,
	input  wire            reset_n,
	input  cpu_pkg::word_t read_data,
	output logic           read_m,
	output logic           write_m,
	output cpu_pkg::word_t address,
	output cpu_pkg::word_t write_data,
	output cpu_pkg::word_t num_inst,
	output cpu_pkg::word_t output_port,
	output logic           is_halted
);
	import cpu_pkg::*;

	word_t pc;
	word_t ir;
	word_t mdr;
	word_t a_reg;
	word_t b_reg;
	word_t alu_out;

	word_t rf_data1;
	word_t rf_data2;
	word_t alu_a;
	word_t alu_b;
	word_t alu_result;
	word_t next_pc;
	word_t imm_sext;
	word_t imm_zext;
	word_t jump_target;
	word_t wb_data;
	reg_addr_t wb_addr;

	logic pc_write;
	logic branch_write;
	logic ir_write;
	logic mdr_write;
	logic i_or_d;
	logic reg_write;
	logic alu_a_sel;
	logic wwd;
	logic done;
	logic halt;
	logic bcond;
	logic [1:0] reg_dest;
	logic [1:0] reg_src;
	logic [1:0] alu_b_sel;
	alu_sel_t alu_sel;

	control_unit u_control (
		.clk          (clk),
		.reset_n      (reset_n),
		.opcode       (ir[15:12]),
		.func         (ir[5:0]),
		.bcond        (bcond),
		.pc_write     (pc_write),
		.branch_write (branch_write),
		.ir_write     (ir_write),
		.mdr_write    (mdr_write),
		.i_or_d       (i_or_d),
		.read_m       (read_m),
		.write_m      (write_m),
		.reg_write    (reg_write),
		.reg_dest     (reg_dest),
		.reg_src      (reg_src),
		.alu_a_sel    (alu_a_sel),
		.alu_b_sel    (alu_b_sel),
		.alu_sel      (alu_sel),
		.wwd          (wwd),
		.done         (done),
		.halt         (halt)
	);

	register_file u_regs (
		.clk        (clk),
		.reset_n    (reset_n),
		.read_addr1 (ir[11:10]),
		.read_addr2 (ir[9:8]),
		.write_addr (wb_addr),
		.write_data (wb_data),
		.write_en   (reg_write),
		.read_data1 (rf_data1),
		.read_data2 (rf_data2)
	);

	alu u_alu (
		.a      (alu_a),
		.b      (alu_b),
		.sel    (alu_sel),
		.result (alu_result),
		.bcond  (bcond)
	);

	assign imm_sext    = {{8{ir[7]}}, ir[7:0]};
	assign imm_zext    = {8'h00, ir[7:0]};
	assign jump_target = {pc[15:12], ir[11:0]};

	assign alu_a = (alu_a_sel == `OPA_REG) ? a_reg : pc;

	always_comb begin
		case (alu_b_sel)
			`OPB_ONE: alu_b = word_t'(1);
			`OPB_SEXT: alu_b = imm_sext;
			`OPB_ZEXT: alu_b = imm_zext;
			default: alu_b = b_reg;
		endcase
	end

	// Fetch increments, a taken branch uses the target from decode
	always_comb begin
		if (ir_write) begin
			next_pc = alu_result;
		end else if (branch_write) begin
			next_pc = alu_out;
		end else if (ir[15:12] == `OPC_JMP || ir[15:12] == `OPC_JAL) begin
			next_pc = jump_target;
		end else begin
			next_pc = a_reg;
		end
	end

	always_comb begin
		case (reg_dest)
			`DEST_RD: wb_addr = ir[7:6];
			`DEST_R2: wb_addr = reg_addr_t'(2);
			default: wb_addr = ir[9:8];
		endcase
	end

	always_comb begin
		case (reg_src)
			`WB_MDR: wb_data = mdr;
			`WB_PC: wb_data = pc;
			default: wb_data = alu_out;
		endcase
	end

	assign address    = i_or_d ? alu_out : pc;
	assign write_data = b_reg;
	assign is_halted  = halt;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			pc          <= '0;
			num_inst    <= '0;
			output_port <= '0;
		end else begin
			if (pc_write || branch_write) begin
				pc <= next_pc;
			end
			if (done) begin
				num_inst <= num_inst + 1'b1;
			end
			if (wwd) begin
				output_port <= a_reg;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ir_write) begin
			ir <= read_data;
		end
		if (mdr_write) begin
			mdr <= read_data;
		end
		// Operands hold while a register is written, so JRL jumps to the old rs
		if (!reg_write) begin
			a_reg <= rf_data1;
			b_reg <= rf_data2;
		end
		alu_out <= alu_result;
	end

endmodule

`default_nettype wire

//--- testbench/cpu_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "cpu_macros.svh"

module cpu_tb;
	import cpu_pkg::*;

	logic clk = 1'b0;
	logic reset_n;
	word_t read_data;
	logic read_m;
	logic write_m;
	word_t address;
	word_t write_data;
	word_t num_inst;
	word_t output_port;
	logic is_halted;

	// Memory model and its load port
	word_t mem [0:65535];
	logic load_en;
	word_t load_addr;
	word_t load_data;

	// Program image and expectations of the current test
	word_t prog [$];
	word_t fill_addr [$];
	word_t fill_data [$];
	int expect_idx [$];
	word_t expect_val [$];
	int exec_count;

	word_t port_trace [$];
	word_t last_count = '0;
	int budget_cycles;
	logic [31:0] rng_state;

	cpu uut (
		.clk         (clk),
		.reset_n     (reset_n),
		.read_data   (read_data),
		.read_m      (read_m),
		.write_m     (write_m),
		.address     (address),
		.write_data  (write_data),
		.num_inst    (num_inst),
		.output_port (output_port),
		.is_halted   (is_halted)
	);

	always #50 clk = ~clk;

	// Data is driven only during a read strobe
	assign read_data = read_m ? mem[address] : '0;

	always @(posedge clk) begin
		if (load_en) begin
			mem[load_addr] <= load_data;
		end else if (write_m) begin
			mem[address] <= write_data;
		end
	end

	// One entry per completed instruction
	always @(negedge clk) begin
		if (!reset_n) begin
			port_trace.delete();
			last_count = '0;
		end else if (num_inst != last_count) begin
			port_trace.push_back(output_port);
			last_count = num_inst;
		end
	end

	initial begin : watchdog
		int cycles;
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > budget_cycles) begin
				$display("Timeout: the CPU did not halt within %0d cycles", budget_cycles);
				$display("CHECKS FAILED");
				$fatal(1, "watchdog expired");
			end
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic random_word(output word_t w);
		rng_state = xorshift(rng_state);
		w = rng_state[31:16];
	endtask

	function automatic word_t fill_pattern(input word_t addr);
		return {addr[7:0], addr[15:8]} ^ 16'hb4c3;
	endfunction

	task automatic check(input string name, input word_t actual, input word_t expected);
		if (actual !== expected) begin
			$display("** Error at %0t ns: %s = 0x%h, expected 0x%h",
				$time, name, actual, expected);
			$display("CHECKS FAILED");
			$fatal(1, "mismatch on %s", name);
		end
	endtask

	// Instruction encoders
	function automatic word_t r_type_word(input logic [5:0] fn, input reg_addr_t rs,
		input reg_addr_t rt, input reg_addr_t rd);
		return {`OPC_RTYPE, rs, rt, rd, fn};
	endfunction

	function automatic word_t i_type_word(input logic [3:0] opc, input reg_addr_t rs,
		input reg_addr_t rt, input logic [7:0] imm);
		return {opc, rs, rt, imm};
	endfunction

	function automatic word_t j_type_word(input logic [3:0] opc, input logic [11:0] target);
		return {opc, target};
	endfunction

	function automatic word_t wwd_word(input reg_addr_t rs);
		return r_type_word(`FN_WWD, rs, 2'd0, 2'd0);
	endfunction

	task automatic new_program();
		prog.delete();
		fill_addr.delete();
		fill_data.delete();
		expect_idx.delete();
		expect_val.delete();
		exec_count = 0;
	endtask

	// Times is how often the word runs on the executed path
	task automatic emit(input word_t w, input int times);
		prog.push_back(w);
		exec_count += times;
	endtask

	task automatic expect_port(input int idx, input word_t value);
		expect_idx.push_back(idx);
		expect_val.push_back(value);
	endtask

	task automatic emit_wwd(input reg_addr_t rs, input word_t expected);
		emit(wwd_word(rs), 1);
		expect_port(exec_count - 1, expected);
	endtask

	task automatic emit_halt();
		emit(r_type_word(`FN_HLT, 2'd0, 2'd0, 2'd0), 1);
	endtask

	task automatic load_const(input reg_addr_t r, input word_t value);
		emit(i_type_word(`OPC_LHI, 2'd0, r, value[15:8]), 1);
		emit(i_type_word(`OPC_ORI, r, r, value[7:0]), 1);
	endtask

	task automatic load_word(input word_t addr, input word_t data);
		load_en = 1'b1;
		load_addr = addr;
		load_data = data;
		@(negedge clk);
	endtask

	// Loads the image under reset, runs to HLT and checks count and port trace
	task automatic run_program();
		int i;
		budget_cycles += prog.size() + fill_addr.size() + 8 + exec_count * 5 + 20;
		@(negedge clk);
		reset_n = 1'b0;
		for (i = 0; i < prog.size(); i++) begin
			load_word(word_t'(i), prog[i]);
		end
		for (i = 0; i < fill_addr.size(); i++) begin
			load_word(fill_addr[i], fill_data[i]);
		end
		load_en = 1'b0;
		repeat (8) @(negedge clk);
		reset_n = 1'b1;
		while (!is_halted) begin
			@(negedge clk);
		end
		@(negedge clk);
		check("num_inst", num_inst, word_t'(exec_count));
		check("completed instructions", word_t'(port_trace.size()), word_t'(exec_count));
		for (i = 0; i < expect_idx.size(); i++) begin
			check($sformatf("output_port after instruction %0d", expect_idx[i] + 1),
				port_trace[expect_idx[i]], expect_val[i]);
		end
	endtask

	task automatic alu_op(input logic [5:0] fn, input word_t expected);
		emit(r_type_word(fn, 2'd0, 2'd1, 2'd2), 1);
		emit_wwd(2'd2, expected);
	endtask

	task automatic alu_test();
		word_t a;
		word_t b;
		word_t r;
		logic [7:0] imm;
		new_program();
		random_word(a);
		random_word(b);
		random_word(r);
		imm = r[7:0];
		load_const(2'd0, a);
		load_const(2'd1, b);
		alu_op(`FN_ADD, a + b);
		alu_op(`FN_SUB, a - b);
		alu_op(`FN_AND, a & b);
		alu_op(`FN_ORR, a | b);
		alu_op(`FN_NOT, ~a);
		alu_op(`FN_TCP, 16'd0 - a);
		alu_op(`FN_SHL, a << 1);
		alu_op(`FN_SHR, word_t'($signed(a) >>> 1));
		emit(i_type_word(`OPC_ADI, 2'd0, 2'd3, imm), 1);
		emit_wwd(2'd3, a + {{8{imm[7]}}, imm});
		emit(i_type_word(`OPC_ORI, 2'd0, 2'd3, imm), 1);
		emit_wwd(2'd3, a | {8'h00, imm});
		emit(i_type_word(`OPC_LHI, 2'd0, 2'd3, imm), 1);
		emit_wwd(2'd3, {imm, 8'h00});
		emit_halt();
		run_program();
	endtask

	task automatic memory_test();
		word_t base;
		word_t addr;
		word_t stored [4];
		logic [7:0] offs [4];
		int k;
		new_program();
		base = 16'h0140;
		// Offsets on both sides of the base
		offs = '{8'h05, 8'h7f, 8'hfe, 8'h80};
		load_const(2'd0, base);
		for (k = 0; k < 4; k++) begin
			random_word(stored[k]);
			addr = base + {{8{offs[k][7]}}, offs[k]};
			fill_addr.push_back(addr);
			fill_data.push_back(fill_pattern(addr));
			load_const(2'd1, stored[k]);
			emit(i_type_word(`OPC_SWD, 2'd0, 2'd1, offs[k]), 1);
		end
		for (k = 0; k < 4; k++) begin
			emit(i_type_word(`OPC_LWD, 2'd0, 2'd2, offs[k]), 1);
			emit_wwd(2'd2, stored[k]);
		end
		emit_halt();
		run_program();
		for (k = 0; k < 4; k++) begin
			addr = base + {{8{offs[k][7]}}, offs[k]};
			check($sformatf("mem[0x%h]", addr), mem[addr], stored[k]);
		end
	endtask

	function automatic bit branch_taken(input logic [3:0] opc, input word_t a, input word_t b);
		case (opc)
			`OPC_BNE: return a != b;
			`OPC_BEQ: return a == b;
			`OPC_BGZ: return $signed(a) > 16'sd0;
			default: return $signed(a) < 16'sd0;
		endcase
	endfunction

	// Branch over a not-taken marker and a JMP to a taken marker
	task automatic branch_case(input logic [3:0] opc, input word_t a, input word_t b);
		word_t marker;
		logic [11:0] after;
		random_word(marker);
		load_const(2'd0, a);
		load_const(2'd1, b);
		load_const(2'd2, marker);
		load_const(2'd3, ~marker);
		after = 12'(prog.size() + 4);
		emit(i_type_word(opc, 2'd0, 2'd1, 8'd2), 1);
		if (branch_taken(opc, a, b)) begin
			emit(wwd_word(2'd3), 0);
			emit(j_type_word(`OPC_JMP, after), 0);
			emit_wwd(2'd2, marker);
		end else begin
			emit_wwd(2'd3, ~marker);
			emit(j_type_word(`OPC_JMP, after), 1);
			emit(wwd_word(2'd2), 0);
		end
	endtask

	task automatic branch_test();
		word_t r;
		new_program();
		random_word(r);
		branch_case(`OPC_BNE, r, r ^ 16'h0100);
		branch_case(`OPC_BNE, r, r);
		branch_case(`OPC_BEQ, r, r);
		branch_case(`OPC_BEQ, r, r ^ 16'h8000);
		branch_case(`OPC_BGZ, {1'b0, r[14:1], 1'b1}, r);
		branch_case(`OPC_BGZ, 16'h0000, r);
		branch_case(`OPC_BGZ, {1'b1, r[14:0]}, r);
		branch_case(`OPC_BLZ, {1'b1, r[14:0]}, r);
		branch_case(`OPC_BLZ, {1'b0, r[14:0]}, r);
		emit_halt();
		run_program();
	endtask

	task automatic jump_test();
		word_t good;
		word_t bad;
		new_program();
		random_word(good);
		random_word(bad);
		load_const(2'd0, good);
		load_const(2'd1, bad);
		// Address of the JRL subroutine
		load_const(2'd3, 16'd14);
		emit(j_type_word(`OPC_JMP, 12'd8), 1);
		emit(wwd_word(2'd1), 0);
		emit(j_type_word(`OPC_JAL, 12'd12), 1);
		emit(wwd_word(2'd0), 1);
		emit(r_type_word(`FN_JRL, 2'd3, 2'd0, 2'd0), 1);
		emit_halt();
		emit(wwd_word(2'd2), 1);
		emit(r_type_word(`FN_JPR, 2'd2, 2'd0, 2'd0), 1);
		emit(wwd_word(2'd2), 1);
		emit(r_type_word(`FN_JPR, 2'd2, 2'd0, 2'd0), 1);
		// Executed order is 0 to 6, 8, 12, 13, 9, 10, 14, 15, 11
		expect_port(8, 16'd9);
		expect_port(10, good);
		expect_port(12, 16'd11);
		run_program();
		check("output_port", output_port, 16'd11);
	endtask

	task automatic count_halt_test();
		word_t r;
		int n;
		new_program();
		random_word(r);
		n = 2 + int'(r[2:0]);
		emit(i_type_word(`OPC_ADI, 2'd0, 2'd0, 8'(n)), 1);
		// Loop body runs n times while r1 stays zero
		emit(i_type_word(`OPC_ADI, 2'd3, 2'd3, 8'd7), n);
		emit(i_type_word(`OPC_ADI, 2'd0, 2'd0, 8'hff), n);
		emit(i_type_word(`OPC_BNE, 2'd0, 2'd1, 8'hfd), n);
		emit_wwd(2'd3, word_t'(7 * n));
		emit_halt();
		run_program();
		budget_cycles += 40;
		repeat (20) begin
			@(negedge clk);
			check("is_halted", word_t'(is_halted), 16'd1);
			check("read_m", word_t'(read_m), 16'd0);
			check("write_m", word_t'(write_m), 16'd0);
		end
		check("num_inst", num_inst, word_t'(exec_count));
		reset_n = 1'b0;
		repeat (8) @(negedge clk);
		check("num_inst", num_inst, 16'd0);
		check("output_port", output_port, 16'd0);
		check("is_halted", word_t'(is_halted), 16'd0);
		reset_n = 1'b1;
	endtask

	initial begin
		reset_n = 1'b0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		rng_state = 32'h79db_66ec;
		budget_cycles = 50;
		alu_test();
		memory_test();
		branch_test();
		jump_test();
		count_halt_test();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+logic
logic/cpu_pkg.sv
logic/register_file.sv
logic/alu.sv
logic/control_unit.sv
logic/cpu.sv
testbench/cpu_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the CPU testbench with Verilator and runs it into sim.log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --timescale 1ns/1ns \
	-f vlog.f --top-module cpu_tb -Mdir obj_dir -o cpu_tb_sim

./obj_dir/cpu_tb_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "CHECKS FAILED" sim.log; then
	echo "Simulation failed"
	exit 1
fi
if ! grep -q "ALL CHECKS PASSED" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
echo "Simulation passed"
